/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = goc_tb
FILELIST  = files.f

BUILD_DIR = obj_dir
SIM       = $(BUILD_DIR)/V$(TOP)
LOG       = sim.log
SOURCES   = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes.
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	grep -q "^all tests passed$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* files.f */
src/goc_pkg.sv
src/header_decoder.sv
src/frame_buffer.sv
src/bit_timer.sv
src/pwm_serializer.sv
src/ack_generator.sv
src/goc_ctrl.sv
src/goc_top.sv
verif/goc_tb.sv

/* src/ack_generator.sv */
`timescale 1ns/1ns

module ack_generator (
	input  logic                          clk,
	input  logic                          reset,
	input  logic                          send_ack,
	input  logic                          send_nak,
	input  logic [goc_pkg::eid_width-1:0] hd_eid,
	output logic [7:0]                    ack_data,
	output logic                          ack_data_valid,
	output logic                          ack_frame_valid
);
	import goc_pkg::*;

	logic [eid_width-1:0] eid_q;
	logic                 second; // EID byte goes out next.

	always_ff @(posedge clk) begin
		if (reset) begin
			ack_frame_valid <= 1'b0;
			ack_data_valid  <= 1'b0;
			second          <= 1'b0;
		end else begin
			if (send_ack || send_nak) begin
				ack_frame_valid <= 1'b1;
				ack_data_valid  <= 1'b1;
				second          <= 1'b1;
			end else if (second) begin
				second <= 1'b0; // Valids stay up for the EID byte.
			end else begin
				ack_frame_valid <= 1'b0;
				ack_data_valid  <= 1'b0;
			end
		end
	end

	// Code byte first, then the EID.
	always_ff @(posedge clk) begin
		if (send_ack || send_nak) begin
			ack_data <= send_nak ? nak_code : ack_code;
			eid_q    <= hd_eid;
		end else if (second) begin
			ack_data <= eid_q;
		end
	end

endmodule

/* src/bit_timer.sv */
`timescale 1ns/1ns

module bit_timer (
	input  logic                            clk,
	input  logic                            reset,
	input  logic                            timer_run,
	input  logic [goc_pkg::speed_width-1:0] goc_speed,
	output logic                            quarter_tick,
	output logic [1:0]                      quarter
);
	import goc_pkg::*;

	logic [speed_width-1:0] cnt;     // Zero means a fresh interval.
	logic [speed_width-1:0] cnt_eff;
	logic [speed_width-1:0] reload;

	// A speed of zero behaves like one.
	assign reload  = (goc_speed == '0) ? speed_width'(1) : goc_speed;
	assign cnt_eff = (cnt == '0) ? reload : cnt;

	// Last cycle of the current quarter.
	assign quarter_tick = timer_run && (cnt_eff == speed_width'(1));

	always_ff @(posedge clk) begin
		if (reset || !timer_run) begin
			cnt     <= '0;
			quarter <= 2'd0;
		end else begin
			if (quarter_tick) begin
				cnt     <= '0; // Reloads from goc_speed next cycle.
				quarter <= quarter + 2'd1;
			end else begin
				cnt <= cnt_eff - speed_width'(1);
			end
		end
	end

endmodule

/* src/frame_buffer.sv */
`timescale 1ns/1ns

module frame_buffer (
	input  logic       clk,
	input  logic       reset,
	input  logic       pl_start,
	input  logic [7:0] pl_data,
	input  logic       pl_write,
	input  logic       fifo_read,
	output logic [7:0] fifo_data,
	output logic       fifo_empty,
	output logic       overflow
);
	import goc_pkg::*;

	logic [7:0]                 mem [fifo_depth];
	logic [fifo_addr_width-1:0] wr_ptr;
	logic [fifo_addr_width-1:0] rd_ptr;
	logic [fifo_addr_width:0]   count;
	logic                       full;
	logic                       do_write;
	logic                       do_read;

	assign full       = (count == (fifo_addr_width + 1)'(fifo_depth));
	assign fifo_empty = (count == '0);
	assign do_write   = pl_write && !full;
	assign do_read    = fifo_read && !fifo_empty;
	assign fifo_data  = mem[rd_ptr]; // Head byte is always visible.

	always_ff @(posedge clk) begin
		if (reset || pl_start) begin
			wr_ptr   <= '0;
			rd_ptr   <= '0;
			count    <= '0;
			overflow <= 1'b0;
		end else begin
			if (do_write)
				wr_ptr <= wr_ptr + 1'b1; // Pointers wrap at the buffer depth.
			if (do_read)
				rd_ptr <= rd_ptr + 1'b1;
			case ({do_write, do_read})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
			// A byte that finds the buffer full is lost, so flag the frame.
			if (pl_write && full)
				overflow <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (do_write)
			mem[wr_ptr] <= pl_data;
	end

endmodule

/* src/goc_ctrl.sv */
`timescale 1ns/1ns

module goc_ctrl (
	input  logic clk,
	input  logic reset,
	input  logic hd_done,
	input  logic overflow,
	input  logic fifo_empty,
	input  logic tx_busy,
	output logic busy,
	output logic tx_enable,
	output logic send_ack,
	output logic send_nak
);
	import goc_pkg::*;

	ctrl_state_t state;
	ctrl_state_t next_state;

	always_comb begin
		next_state = state;
		case (state)
			ctrl_idle: begin
				// An overflowed payload is never sent.
				if (hd_done)
					next_state = overflow ? ctrl_reply : ctrl_transmit;
			end
			ctrl_transmit: begin
				if (fifo_empty && !tx_busy)
					next_state = ctrl_reply; // Last bit has left the pad.
			end
			ctrl_reply: next_state = ctrl_idle;
			default:    next_state = ctrl_idle;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset)
			state <= ctrl_idle;
		else
			state <= next_state;
	end

	// New frames are refused until the reply has been started.
	assign busy      = (state != ctrl_idle);
	assign tx_enable = (state == ctrl_transmit);

	// Overflow only clears on the next accepted frame, so it still holds here.
	assign send_ack = (state == ctrl_reply) && !overflow;
	assign send_nak = (state == ctrl_reply) && overflow;

endmodule

/* src/goc_pkg.sv */
package goc_pkg;

	// Bus address this node answers to.
	localparam logic [7:0] node_addr = 8'h66;

	// Event id carried in the second header byte and echoed in the reply.
	localparam int eid_width = 8;

	// First byte of the reply frame.
	localparam logic [7:0] ack_code = 8'hA5; // Payload sent on the pad.
	localparam logic [7:0] nak_code = 8'h5A; // Payload overflowed, nothing sent.

	// Payload buffer geometry.
	// The count needs one bit more than the pointers to tell full from empty.
	localparam int unsigned fifo_depth = 16;
	localparam int fifo_addr_width = 4;

	// Width of the quarter-bit interval setting.
	localparam int speed_width = 22;

	// Controller states.
	typedef enum logic [1:0] {
		ctrl_idle     = 2'd0, // Waiting for an accepted frame.
		ctrl_transmit = 2'd1, // Payload going out on the pad.
		ctrl_reply    = 2'd2  // One cycle, starts the reply frame.
	} ctrl_state_t;

endpackage

/* src/goc_top.sv */
`timescale 1ns/1ns

module goc_top (
	input  logic                            clk,
	input  logic                            reset,
	input  logic [goc_pkg::speed_width-1:0] goc_speed,
	input  logic                            goc_polarity,
	input  logic [7:0]                      ma_data,
	input  logic                            ma_data_valid,
	input  logic                            ma_frame_valid,
	output logic                            goc_pad,
	output logic [7:0]                      ack_data,
	output logic                            ack_data_valid,
	output logic                            ack_frame_valid
);
	import goc_pkg::*;

	logic [eid_width-1:0] hd_eid;
	logic [7:0]           pl_data;
	logic                 pl_write;
	logic                 pl_start;
	logic                 hd_done;
	logic [7:0]           fifo_data;
	logic                 fifo_empty;
	logic                 fifo_read;
	logic                 overflow;
	logic                 busy;
	logic                 tx_enable;
	logic                 tx_busy;
	logic                 send_ack;
	logic                 send_nak;
	logic                 timer_run;
	logic                 quarter_tick;
	logic [1:0]           quarter;
	logic                 pwm_out;

	header_decoder u_header_decoder (
		.clk(clk), .reset(reset),
		.ma_data(ma_data), .ma_data_valid(ma_data_valid), .ma_frame_valid(ma_frame_valid),
		.busy(busy), .hd_eid(hd_eid),
		.pl_data(pl_data), .pl_write(pl_write), .pl_start(pl_start), .hd_done(hd_done)
	);

	frame_buffer u_frame_buffer (
		.clk(clk), .reset(reset),
		.pl_start(pl_start), .pl_data(pl_data), .pl_write(pl_write), .fifo_read(fifo_read),
		.fifo_data(fifo_data), .fifo_empty(fifo_empty), .overflow(overflow)
	);

	bit_timer u_bit_timer (
		.clk(clk), .reset(reset), .timer_run(timer_run), .goc_speed(goc_speed),
		.quarter_tick(quarter_tick), .quarter(quarter)
	);

	pwm_serializer u_pwm_serializer (
		.clk(clk), .reset(reset), .tx_enable(tx_enable),
		.fifo_data(fifo_data), .fifo_empty(fifo_empty),
		.quarter_tick(quarter_tick), .quarter(quarter),
		.fifo_read(fifo_read), .timer_run(timer_run), .tx_busy(tx_busy), .pwm_out(pwm_out)
	);

	ack_generator u_ack_generator (
		.clk(clk), .reset(reset), .send_ack(send_ack), .send_nak(send_nak), .hd_eid(hd_eid),
		.ack_data(ack_data), .ack_data_valid(ack_data_valid), .ack_frame_valid(ack_frame_valid)
	);

	goc_ctrl u_goc_ctrl (
		.clk(clk), .reset(reset), .hd_done(hd_done), .overflow(overflow),
		.fifo_empty(fifo_empty), .tx_busy(tx_busy),
		.busy(busy), .tx_enable(tx_enable), .send_ack(send_ack), .send_nak(send_nak)
	);

	assign goc_pad = pwm_out ^ goc_polarity; // Pad idles at the polarity level.

endmodule

/* src/header_decoder.sv */
`timescale 1ns/1ns

module header_decoder (
	input  logic                          clk,
	input  logic                          reset,
	input  logic [7:0]                    ma_data,
	input  logic                          ma_data_valid,
	input  logic                          ma_frame_valid,
	input  logic                          busy,
	output logic [goc_pkg::eid_width-1:0] hd_eid,
	output logic [7:0]                    pl_data,
	output logic                          pl_write,
	output logic                          pl_start,
	output logic                          hd_done
);
	import goc_pkg::*;

	logic [1:0] byte_cnt; // Saturates at 2, every byte from there on is payload.
	logic       accepted; // Current frame is ours.
	logic       frame_q;  // Last cycle's frame_valid, for the falling edge.

	always_ff @(posedge clk) begin
		if (reset) begin
			byte_cnt <= '0;
			accepted <= 1'b0;
			frame_q  <= 1'b0;
			pl_start <= 1'b0;
			pl_write <= 1'b0;
			hd_done  <= 1'b0;
		end else begin
			frame_q  <= ma_frame_valid;
			pl_start <= 1'b0;
			pl_write <= 1'b0;
			hd_done  <= 1'b0;
			if (!ma_frame_valid) begin
				// End of frame, or the gap between frames.
				byte_cnt <= '0;
				accepted <= 1'b0;
				if (frame_q && accepted)
					hd_done <= 1'b1;
			end else if (ma_data_valid) begin
				if (byte_cnt != 2'd2)
					byte_cnt <= byte_cnt + 2'd1;
				if (byte_cnt == 2'd0 && ma_data == node_addr && !busy) begin
					accepted <= 1'b1;
					pl_start <= 1'b1; // Clears the buffer for the new payload.
				end
				if (byte_cnt == 2'd2 && accepted)
					pl_write <= 1'b1;
			end
		end
	end

	// Header and payload bytes.
	always_ff @(posedge clk) begin
		if (ma_frame_valid && ma_data_valid && accepted) begin
			if (byte_cnt == 2'd1)
				hd_eid <= ma_data;
			pl_data <= ma_data;
		end
	end

endmodule

/* src/pwm_serializer.sv */
`timescale 1ns/1ns

module pwm_serializer (
	input  logic       clk,
	input  logic       reset,
	input  logic       tx_enable,
	input  logic [7:0] fifo_data,
	input  logic       fifo_empty,
	input  logic       quarter_tick,
	input  logic [1:0] quarter,
	output logic       fifo_read,
	output logic       timer_run,
	output logic       tx_busy,
	output logic       pwm_out
);

	logic [7:0] shift;   // MSB is the bit on the pad.
	logic [2:0] bit_cnt; // Bits left after the current one.
	logic       loaded;
	logic       bit_end;
	logic       byte_end;
	logic       load;

	assign bit_end  = quarter_tick && (quarter == 2'd3);
	assign byte_end = bit_end && (bit_cnt == 3'd0);

	// Fetch at start, or at the end of the last bit so bytes run back to back.
	assign load = tx_enable && !fifo_empty && (!loaded || byte_end);

	assign fifo_read = load;
	assign timer_run = loaded;
	assign tx_busy   = loaded;

	// Quarter 0 is always high, quarters 1 and 2 follow the bit, quarter 3 is low.
	assign pwm_out = loaded && ((quarter == 2'd0) || (shift[7] && quarter != 2'd3));

	always_ff @(posedge clk) begin
		if (reset) begin
			loaded  <= 1'b0;
			bit_cnt <= 3'd0;
		end else begin
			if (load) begin
				loaded  <= 1'b1;
				bit_cnt <= 3'd7;
			end else if (byte_end) begin
				loaded <= 1'b0; // Nothing left to send.
			end else if (bit_end) begin
				bit_cnt <= bit_cnt - 3'd1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (load)
			shift <= fifo_data;
		else if (bit_end)
			shift <= {shift[6:0], 1'b0}; // Next bit, MSB first.
	end

endmodule

/* verif/goc_tb.sv */
`timescale 1ns/1ns

module goc_tb;

	localparam logic [7:0] our_addr  = 8'h66;
	localparam logic [7:0] ack_reply = 8'hA5;
	localparam logic [7:0] nak_reply = 8'h5A;
	localparam int         n_tests   = 8;

	// One row per test.
	string       row_name [n_tests] = '{"single_byte", "full_buffer", "other_addr", "overflow",
		"inverted_pad", "empty_payload", "busy_drop", "zero_speed"};
	logic [7:0]  row_addr [n_tests] = '{our_addr, our_addr, 8'h35, our_addr,
		our_addr, our_addr, our_addr, our_addr};
	logic [7:0]  row_eid [n_tests] = '{8'h11, 8'h2c, 8'h3e, 8'h47, 8'h5b, 8'h60, 8'h7f, 8'h81};
	int          row_len [n_tests] = '{1, 16, 4, 17, 3, 0, 2, 2};
	logic [21:0] row_speed [n_tests] = '{22'd2, 22'd1, 22'd1, 22'd1, 22'd3, 22'd2, 22'd2, 22'd0};
	logic        row_pol [n_tests] = '{0, 0, 0, 0, 1, 1, 0, 0};
	logic        row_overlap [n_tests] = '{0, 0, 0, 0, 0, 0, 1, 0}; // Second frame while busy.
	logic        row_reply_on [n_tests] = '{1, 1, 0, 1, 1, 1, 1, 1};
	logic [7:0]  row_reply [n_tests] = '{ack_reply, ack_reply, 8'h00, nak_reply,
		ack_reply, ack_reply, ack_reply, ack_reply};

	logic        clk = 1'b0;
	logic        reset;
	logic [21:0] goc_speed;
	logic        goc_polarity;
	logic [7:0]  ma_data;
	logic        ma_data_valid;
	logic        ma_frame_valid;
	logic        goc_pad;
	logic [7:0]  ack_data;
	logic        ack_data_valid;
	logic        ack_frame_valid;

	logic [31:0] lfsr_state = 32'h6a7d;
	logic [7:0]  exp_bytes [$];   // Payload expected on the pad.
	logic [7:0]  pad_bytes [$];   // Bytes rebuilt from the pad.
	logic [7:0]  reply_bytes [$];
	int          reply_lens [$];  // Cycles of ack_frame_valid per reply frame.
	int          reply_marks [$]; // Pad bits counted when each reply frame began.
	int          pad_bits = 0;
	int          high_cnt = 0;
	int          reply_cycles = 0;
	logic [7:0]  cur_byte = '0;
	logic        bit_val;
	logic        pad_level;
	string       cur_test = "reset";
	int          mismatch_errors = 0;
	int          other_errors = 0;

	goc_top dut (
		.clk(clk), .reset(reset), .goc_speed(goc_speed), .goc_polarity(goc_polarity),
		.ma_data(ma_data), .ma_data_valid(ma_data_valid), .ma_frame_valid(ma_frame_valid),
		.goc_pad(goc_pad), .ack_data(ack_data), .ack_data_valid(ack_data_valid),
		.ack_frame_valid(ack_frame_valid)
	);

	always #10 clk = ~clk;

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	function automatic int eff_speed(input logic [21:0] s);
		return (s == '0) ? 1 : int'(s); // Zero behaves like one.
	endfunction

	function automatic int test_budget(input int i);
		return 40 + row_len[i] * 32 * eff_speed(row_speed[i]);
	endfunction

	task automatic report_mismatch(input string what, input int expected, input int actual);
		mismatch_errors++;
		$display("mismatch %s %s: expected 0x%0h, actual 0x%0h", cur_test, what, expected, actual);
	endtask

	task automatic flag_failure(input string msg);
		other_errors++;
		$display("%s: %s", cur_test, msg);
	endtask

	// One LFSR step per payload bit.
	task automatic draw_byte(output logic [7:0] value);
		value = '0;
		for (int k = 0; k < 8; k++) begin
			value = {value[6:0], lfsr_state[0]};
			lfsr_state = lfsr_step(lfsr_state);
		end
	endtask

	task automatic put_byte(input logic [7:0] value);
		@(posedge clk);
		ma_data       <= value;
		ma_data_valid <= 1'b1;
		@(posedge clk);
		ma_data_valid <= 1'b0;
	endtask

	task automatic send_frame(input logic [7:0] addr, input logic [7:0] eid, input int len,
		input bit record);
		logic [7:0] value;
		@(posedge clk);
		ma_frame_valid <= 1'b1;
		put_byte(addr);
		put_byte(eid);
		for (int k = 0; k < len; k++) begin
			draw_byte(value);
			if (record)
				exp_bytes.push_back(value);
			put_byte(value);
		end
		@(posedge clk);
		ma_frame_valid <= 1'b0; // Falling edge closes the frame.
	endtask

	task automatic check_results(input int i, input int bit0, input int byte0, input int rep0,
		input int rbyte0);
		int n_replies;
		n_replies = reply_lens.size() - rep0;
		assert (pad_bits - bit0 == exp_bytes.size() * 8)
		else report_mismatch("pad bit count", exp_bytes.size() * 8, pad_bits - bit0);
		for (int k = 0; k < exp_bytes.size() && byte0 + k < pad_bytes.size(); k++)
			assert (pad_bytes[byte0 + k] == exp_bytes[k])
			else report_mismatch($sformatf("pad byte %0d", k), exp_bytes[k], pad_bytes[byte0 + k]);
		if (row_reply_on[i]) begin
			assert (n_replies > 0) else flag_failure("no reply frame seen");
			if (n_replies > 0) begin
				assert (n_replies == 1) else report_mismatch("reply frame count", 1, n_replies);
				assert (reply_lens[rep0] == 2)
				else report_mismatch("reply frame length", 2, reply_lens[rep0]);
				// The reply only starts once every payload bit has left the pad.
				assert (reply_marks[rep0] - bit0 == exp_bytes.size() * 8)
				else report_mismatch("pad bits before reply", exp_bytes.size() * 8,
					reply_marks[rep0] - bit0);
				assert (reply_bytes.size() - rbyte0 >= 2)
				else flag_failure("reply frame carried fewer than two bytes");
				if (reply_bytes.size() - rbyte0 >= 2) begin
					assert (reply_bytes[rbyte0] == row_reply[i])
					else report_mismatch("reply code", row_reply[i], reply_bytes[rbyte0]);
					assert (reply_bytes[rbyte0 + 1] == row_eid[i])
					else report_mismatch("reply eid", row_eid[i], reply_bytes[rbyte0 + 1]);
				end
			end
		end else begin
			assert (n_replies == 0) else flag_failure("unexpected reply frame");
		end
	endtask

	// Pad decoder. Each high pulse is one bit, classified by its length.
	assign pad_level = goc_pad ^ goc_polarity;

	always @(posedge clk) begin
		if (!reset) begin
			if (pad_level) begin
				high_cnt++;
			end else if (high_cnt != 0) begin
				assert (high_cnt == 3 * eff_speed(goc_speed) || high_cnt == eff_speed(goc_speed))
				else flag_failure($sformatf("pad pulse of %0d cycles is neither short nor long",
					high_cnt));
				bit_val  = (high_cnt == 3 * eff_speed(goc_speed));
				cur_byte = {cur_byte[6:0], bit_val}; // MSB arrives first.
				pad_bits++;
				if (pad_bits % 8 == 0)
					pad_bytes.push_back(cur_byte);
				high_cnt = 0;
			end
		end
	end

	// Reply monitor.
	always @(posedge clk) begin
		if (!reset) begin
			if (ack_frame_valid) begin
				if (reply_cycles == 0)
					reply_marks.push_back(pad_bits);
				reply_cycles++;
				if (ack_data_valid)
					reply_bytes.push_back(ack_data);
			end else begin
				assert (!ack_data_valid)
				else flag_failure("ack_data_valid high outside a reply frame");
				if (reply_cycles != 0) begin
					reply_lens.push_back(reply_cycles);
					reply_cycles = 0;
				end
			end
		end
	end

	initial begin : watchdog
		int limit;
		limit = 100;
		for (int i = 0; i < n_tests; i++)
			limit += test_budget(i) + 4 * (row_len[i] + 4) + 100;
		repeat (limit) @(posedge clk);
		$display("watchdog expired after %0d cycles in test %s", limit, cur_test);
		$display("tests failed");
		$finish;
	end

	initial begin : main
		int bit0;
		int byte0;
		int rep0;
		int rbyte0;
		int cyc;
		reset          <= 1'b1;
		goc_speed      <= '0;
		goc_polarity   <= 1'b0;
		ma_data        <= '0;
		ma_data_valid  <= 1'b0;
		ma_frame_valid <= 1'b0;
		repeat (4) @(posedge clk);
		reset <= 1'b0;
		repeat (2) @(posedge clk);
		assert (goc_pad == 1'b0) else report_mismatch("pad after reset", 0, goc_pad);
		assert (!ack_frame_valid && !ack_data_valid)
		else flag_failure("reply bus active after reset");

		for (int i = 0; i < n_tests; i++) begin
			@(posedge clk);
			cur_test     = row_name[i];
			goc_speed    <= row_speed[i];
			goc_polarity <= row_pol[i];
			repeat (3) @(posedge clk);
			assert (goc_pad == row_pol[i])
			else report_mismatch("idle pad level", row_pol[i], goc_pad);
			bit0   = pad_bits;
			byte0  = pad_bytes.size();
			rep0   = reply_lens.size();
			rbyte0 = reply_bytes.size();
			exp_bytes.delete();
			// Only a frame for this node that fits the buffer reaches the pad.
			send_frame(row_addr[i], row_eid[i], row_len[i],
				row_addr[i] == our_addr && row_len[i] <= 16);
			if (row_overlap[i]) begin
				repeat (6) @(posedge clk);
				send_frame(our_addr, ~row_eid[i], 3, 1'b0);
			end
			cyc = 0;
			while (reply_lens.size() == rep0 && cyc < test_budget(i)) begin
				@(posedge clk);
				cyc++;
			end
			repeat (20) @(posedge clk); // Catch stray pulses or replies.
			check_results(i, bit0, byte0, rep0, rbyte0);
		end

		repeat (2) @(posedge clk);
		$display("%0d mismatches, %0d other failures", mismatch_errors, other_errors);
		if (mismatch_errors + other_errors == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule
